// ==== hw/fpu_defs.svh ====
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// canonical quiet nan with positive sign and only the quiet bit set
`define FPU_QNAN(e_w, m_w) {1'b0, {(e_w){1'b1}}, 1'b1, {((m_w)-1){1'b0}}}

// signed infinity
`define FPU_INF(s, e_w, m_w) {(s), {(e_w){1'b1}}, {(m_w){1'b0}}}

// signed zero
`define FPU_ZERO(s, e_w, m_w) {(s), {((e_w)+(m_w)){1'b0}}}

`endif

// ==== hw/fpu_pkg.sv ====
package fpu_pkg;

  // default format is IEEE single precision
  parameter int exp_width_default = 8;
  parameter int man_width_default = 23;

  // special-case class that the aligner resolves for one operation
  // the first matching case wins
  typedef enum logic [2:0] {
    spc_none,
    spc_sig_nan,
    spc_qnan,
    spc_inf_inf,
    spc_inf,
    spc_denormal
  } special_e;

endpackage

// ==== hw/fpu_class_if.sv ====
`timescale 1ns/1ns

// fields and flags of one operand
interface fpu_class_if #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
);

  logic           sign;
  logic [e_p-1:0] exp;
  logic [m_p-1:0] man;
  logic           nan;
  logic           sig_nan;
  logic           infty;
  logic           denormal;

  modport preprocessor (output sign, exp, man, nan, sig_nan, infty, denormal);

  modport aligner (input sign, exp, man, nan, sig_nan, infty, denormal);

endinterface

// ==== hw/fpu_preprocess.sv ====
`timescale 1ns/1ns

module fpu_preprocess #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
) (
  input  logic [e_p+m_p:0]      a_i,
  fpu_class_if.preprocessor     cls_o
);

  logic [e_p-1:0] exp_f;
  logic [m_p-1:0] man_f;
  logic           exp_ones;
  logic           exp_zero;
  logic           man_zero;

  assign exp_f = a_i[m_p+:e_p];
  assign man_f = a_i[m_p-1:0];

  assign exp_ones = &exp_f;
  assign exp_zero = ~|exp_f;
  assign man_zero = ~|man_f;

  assign cls_o.sign = a_i[e_p+m_p];
  assign cls_o.exp  = exp_f;
  assign cls_o.man  = man_f;

  // all-ones exponent is inf or nan
  // mantissa msb is the quiet bit
  assign cls_o.nan     = exp_ones & ~man_zero;
  assign cls_o.sig_nan = exp_ones & ~man_zero & ~man_f[m_p-1];
  assign cls_o.infty   = exp_ones & man_zero;

  // zero exponent with nonzero fraction
  assign cls_o.denormal = exp_zero & ~man_zero;

endmodule

// ==== hw/fpu_align.sv ====
`timescale 1ns/1ns

module fpu_align #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
) (
  fpu_class_if.aligner        a_i,
  fpu_class_if.aligner        b_i,
  input  logic                sub_i,
  output logic                sign_o,
  output logic                do_sub_o,
  output logic [e_p-1:0]      exp_o,
  output logic [m_p+3:0]      big_man_o,
  output logic [m_p+3:0]      small_man_o,
  output fpu_pkg::special_e   class_o
);

  import fpu_pkg::*;

  logic           exp_a_less;
  logic           mag_a_less;
  logic [e_p-1:0] exp_diff;
  logic [m_p:0]   big_man;
  logic [m_p:0]   small_man;
  logic [m_p+2:0] small_ext;
  logic [m_p+2:0] shift_mask;
  logic           sticky;

  // order by exponent
  assign exp_a_less = a_i.exp < b_i.exp;
  assign exp_diff   = exp_a_less ? b_i.exp - a_i.exp : a_i.exp - b_i.exp;

  // one extra for the carry position of the adder
  assign exp_o = (exp_a_less ? b_i.exp : a_i.exp) + 1'b1;

  // hidden bit always set as denormals are caught by the class
  assign big_man   = exp_a_less ? {1'b1, b_i.man} : {1'b1, a_i.man};
  assign small_man = exp_a_less ? {1'b1, a_i.man} : {1'b1, b_i.man};

  // two guard bits below the smaller mantissa
  assign small_ext = {small_man, 2'b00};

  // bits that fall off the right end collapse into sticky
  assign shift_mask = ~({(m_p+3){1'b1}} << exp_diff);
  assign sticky     = |(small_ext & shift_mask);

  assign big_man_o   = {big_man, 3'b000};
  assign small_man_o = {small_ext >> exp_diff, sticky};

  // sign follows the operand of larger magnitude
  assign mag_a_less = {a_i.exp, a_i.man} < {b_i.exp, b_i.man};

  assign sign_o = (a_i.sign & ~mag_a_less)
                | (~b_i.sign & mag_a_less & sub_i)
                | (b_i.sign & mag_a_less & ~sub_i);

  assign do_sub_o = sub_i ^ a_i.sign ^ b_i.sign;

  always_comb begin
    if (a_i.sig_nan | b_i.sig_nan) begin
      class_o = spc_sig_nan;
    end else if (a_i.nan | b_i.nan) begin
      class_o = spc_qnan;
    end else if (a_i.infty & b_i.infty & do_sub_o) begin
      class_o = spc_inf_inf;
    end else if (a_i.infty | b_i.infty) begin
      class_o = spc_inf;
    end else if (a_i.denormal | b_i.denormal) begin
      class_o = spc_denormal;
    end else begin
      class_o = spc_none;
    end
  end

endmodule

// ==== hw/fpu_normalize.sv ====
`timescale 1ns/1ns

module fpu_normalize #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
) (
  input  logic [m_p+4:0]     sum_i,
  input  logic [e_p-1:0]     exp_i,
  output logic [e_p+m_p-1:0] frac_o,
  output logic               round_up_o,
  output logic               all_zero_o,
  output logic               exp_borrow_o
);

  localparam int cnt_w = $clog2(m_p + 6);

  logic [cnt_w-1:0] num_zero;
  logic             found;
  logic [m_p+4:0]   shifted;
  logic [e_p-1:0]   adj_exp;

  // leading zero count from the msb down
  always_comb begin
    num_zero = '0;
    found    = 1'b0;
    for (int i = m_p + 4; i >= 0; i--) begin
      if (!found) begin
        if (sum_i[i]) begin
          found = 1'b1;
        end else begin
          num_zero = num_zero + 1'b1;
        end
      end
    end
  end

  assign all_zero_o = ~|sum_i;
  assign shifted    = sum_i << num_zero;

  // borrow out means the exponent went below zero
  assign {exp_borrow_o, adj_exp} = {1'b0, exp_i} - (e_p+1)'(num_zero);

  // hidden bit at the top is dropped
  assign frac_o = {adj_exp, shifted[4+:m_p]};

  // nearest even rounds up on the round bit and (sticky or lsb)
  assign round_up_o = shifted[3] & ((|shifted[2:0]) | shifted[4]);

endmodule

// ==== hw/fpu_round_pack.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module fpu_round_pack #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
) (
  input  logic [e_p+m_p-1:0] frac_i,
  input  logic               round_up_i,
  input  logic               all_zero_i,
  input  logic               exp_borrow_i,
  input  logic               sign_i,
  input  fpu_pkg::special_e  class_i,
  input  logic               do_sub_i,
  output logic [e_p+m_p:0]   z_o,
  output logic               invalid_o,
  output logic               unimplemented_o,
  output logic               overflow_o,
  output logic               underflow_o
);

  import fpu_pkg::*;

  logic [e_p-1:0]     exp_pre;
  logic [e_p+m_p-1:0] rounded;
  logic               carry_into_exp;
  logic               exp_max;
  logic               exp_min;

  assign exp_pre = frac_i[m_p+:e_p];
  assign rounded = frac_i + round_up_i;

  // increment ripples through the whole mantissa
  assign carry_into_exp = round_up_i & (&frac_i[m_p-1:0]);

  assign exp_max = (exp_pre == {e_p{1'b1}}) | (rounded[m_p+:e_p] == {e_p{1'b1}});
  assign exp_min = (exp_pre == {e_p{1'b0}}) & ~carry_into_exp;

  always_comb begin
    z_o             = {sign_i, rounded};
    invalid_o       = 1'b0;
    unimplemented_o = 1'b0;
    overflow_o      = 1'b0;
    underflow_o     = 1'b0;
    unique case (class_i)
      spc_sig_nan, spc_inf_inf: begin
        z_o       = `FPU_QNAN(e_p, m_p);
        invalid_o = 1'b1;
      end
      spc_qnan: begin
        z_o = `FPU_QNAN(e_p, m_p);
      end
      spc_inf: begin
        z_o = `FPU_INF(sign_i, e_p, m_p);
      end
      spc_denormal: begin
        z_o             = `FPU_QNAN(e_p, m_p);
        unimplemented_o = 1'b1;
      end
      default: begin
        if (all_zero_i) begin
          // exact cancellation gives +0 under nearest even
          z_o = `FPU_ZERO(sign_i & ~do_sub_i, e_p, m_p);
        end else if (exp_borrow_i | exp_min) begin
          z_o         = `FPU_ZERO(sign_i, e_p, m_p);
          underflow_o = 1'b1;
        end else if (exp_max) begin
          z_o        = `FPU_INF(sign_i, e_p, m_p);
          overflow_o = 1'b1;
        end
      end
    endcase
  end

endmodule

// ==== hw/fpu_add_sub.sv ====
`timescale 1ns/1ns

module fpu_add_sub #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             en_i,
  input  logic             v_i,
  input  logic [e_p+m_p:0] a_i,
  input  logic [e_p+m_p:0] b_i,
  input  logic             sub_i,
  output logic             ready_o,
  output logic             v_o,
  output logic [e_p+m_p:0] z_o,
  output logic             unimplemented_o,
  output logic             invalid_o,
  output logic             overflow_o,
  output logic             underflow_o,
  input  logic             yumi_i
);

  import fpu_pkg::*;

  logic v_1_r;
  logic v_2_r;
  logic v_3_r;
  logic stall;
  logic advance;

  // held result freezes everything
  assign stall   = v_3_r & ~yumi_i;
  assign advance = en_i & ~stall;
  assign ready_o = advance;
  assign v_o     = v_3_r;

  fpu_class_if #(.e_p(e_p), .m_p(m_p)) cls_a ();
  fpu_class_if #(.e_p(e_p), .m_p(m_p)) cls_b ();

  fpu_preprocess #(.e_p(e_p), .m_p(m_p)) pre_a_i (
    .a_i   (a_i),
    .cls_o (cls_a)
  );

  fpu_preprocess #(.e_p(e_p), .m_p(m_p)) pre_b_i (
    .a_i   (b_i),
    .cls_o (cls_b)
  );

  logic           sign_0;
  logic           do_sub_0;
  logic [e_p-1:0] exp_0;
  logic [m_p+3:0] big_man_0;
  logic [m_p+3:0] small_man_0;
  special_e       class_0;

  fpu_align #(.e_p(e_p), .m_p(m_p)) align_i (
    .a_i         (cls_a),
    .b_i         (cls_b),
    .sub_i       (sub_i),
    .sign_o      (sign_0),
    .do_sub_o    (do_sub_0),
    .exp_o       (exp_0),
    .big_man_o   (big_man_0),
    .small_man_o (small_man_0),
    .class_o     (class_0)
  );

  // stage 1 holds the aligned operands
  logic           sign_1_r;
  logic           do_sub_1_r;
  logic [e_p-1:0] exp_1_r;
  logic [m_p+3:0] big_man_1_r;
  logic [m_p+3:0] small_man_1_r;
  special_e       class_1_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_1_r <= 1'b0;
    end else if (advance) begin
      v_1_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance & v_i) begin
      sign_1_r      <= sign_0;
      do_sub_1_r    <= do_sub_0;
      exp_1_r       <= exp_0;
      big_man_1_r   <= big_man_0;
      small_man_1_r <= small_man_0;
      class_1_r     <= class_0;
    end
  end

  // equal exponents can still leave the shifted one larger
  logic           swap;
  logic [m_p+3:0] mag_hi;
  logic [m_p+3:0] mag_lo;
  logic [m_p+4:0] sum_1;

  assign swap   = big_man_1_r < small_man_1_r;
  assign mag_hi = swap ? small_man_1_r : big_man_1_r;
  assign mag_lo = swap ? big_man_1_r : small_man_1_r;

  // subtract as add of the two's complement
  assign sum_1 = {1'b0, mag_hi}
               + {do_sub_1_r, ({(m_p+4){do_sub_1_r}} ^ mag_lo)}
               + do_sub_1_r;

  // stage 2 holds the raw sum
  logic [m_p+4:0] sum_2_r;
  logic [e_p-1:0] exp_2_r;
  logic           sign_2_r;
  logic           do_sub_2_r;
  special_e       class_2_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_2_r <= 1'b0;
    end else if (advance) begin
      v_2_r <= v_1_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance & v_1_r) begin
      sum_2_r    <= sum_1;
      exp_2_r    <= exp_1_r;
      sign_2_r   <= sign_1_r;
      do_sub_2_r <= do_sub_1_r;
      class_2_r  <= class_1_r;
    end
  end

  logic [e_p+m_p-1:0] frac_2;
  logic               round_up_2;
  logic               all_zero_2;
  logic               exp_borrow_2;

  fpu_normalize #(.e_p(e_p), .m_p(m_p)) norm_i (
    .sum_i        (sum_2_r),
    .exp_i        (exp_2_r),
    .frac_o       (frac_2),
    .round_up_o   (round_up_2),
    .all_zero_o   (all_zero_2),
    .exp_borrow_o (exp_borrow_2)
  );

  // stage 3 holds the normalized word ready to round
  logic [e_p+m_p-1:0] frac_3_r;
  logic               round_up_3_r;
  logic               all_zero_3_r;
  logic               exp_borrow_3_r;
  logic               sign_3_r;
  logic               do_sub_3_r;
  special_e           class_3_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_3_r <= 1'b0;
    end else if (advance) begin
      v_3_r <= v_2_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance & v_2_r) begin
      frac_3_r       <= frac_2;
      round_up_3_r   <= round_up_2;
      all_zero_3_r   <= all_zero_2;
      exp_borrow_3_r <= exp_borrow_2;
      sign_3_r       <= sign_2_r;
      do_sub_3_r     <= do_sub_2_r;
      class_3_r      <= class_2_r;
    end
  end

  fpu_round_pack #(.e_p(e_p), .m_p(m_p)) pack_i (
    .frac_i          (frac_3_r),
    .round_up_i      (round_up_3_r),
    .all_zero_i      (all_zero_3_r),
    .exp_borrow_i    (exp_borrow_3_r),
    .sign_i          (sign_3_r),
    .class_i         (class_3_r),
    .do_sub_i        (do_sub_3_r),
    .z_o             (z_o),
    .invalid_o       (invalid_o),
    .unimplemented_o (unimplemented_o),
    .overflow_o      (overflow_o),
    .underflow_o     (underflow_o)
  );

endmodule

// ==== tests/fpu_add_sub_sva.sv ====
`timescale 1ns/1ns

module fpu_add_sub_sva #(
  parameter int e_p = fpu_pkg::exp_width_default,
  parameter int m_p = fpu_pkg::man_width_default
) (
  input logic              clk_i,
  input logic              reset_i,
  input logic              v_o,
  input logic              yumi_i,
  input logic [e_p+m_p:0]  z_o,
  input logic              unimplemented_o,
  input logic              overflow_o,
  input logic              underflow_o
);

  // valid bits are cleared by reset
  reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !v_o)
    else $error("output valid was high in the cycle after reset");

  // a held result stays put until taken
  hold_under_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(z_o)))
    else $error("held result changed or dropped before yumi");

  range_flags_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o |-> $onehot0({overflow_o, underflow_o, unimplemented_o}))
    else $error("more than one of overflow, underflow and unimplemented is high");

endmodule

// ==== tests/fpu_add_sub_tb.sv ====
`timescale 1ns/1ns
`include "fpu_defs.svh"

module fpu_add_sub_tb;

  import fpu_pkg::*;

  localparam int e_w       = exp_width_default;
  localparam int m_w       = man_width_default;
  localparam int w         = e_w + m_w + 1;
  localparam int num_vec   = 24;
  localparam int num_items = 2 * num_vec;

  // flag order is invalid, unimplemented, overflow, underflow
  localparam logic [3:0] fl_none  = 4'b0000;
  localparam logic [3:0] fl_inv   = 4'b1000;
  localparam logic [3:0] fl_unimp = 4'b0100;
  localparam logic [3:0] fl_ovf   = 4'b0010;
  localparam logic [3:0] fl_unf   = 4'b0001;

  logic         clk_i;
  logic         reset_i;
  logic         en_i;
  logic         v_i;
  logic [w-1:0] a_i;
  logic [w-1:0] b_i;
  logic         sub_i;
  logic         yumi_i;
  logic         ready_o;
  logic         v_o;
  logic [w-1:0] z_o;
  logic         unimplemented_o;
  logic         invalid_o;
  logic         overflow_o;
  logic         underflow_o;

  string        vec_name [num_vec];
  logic [w-1:0] vec_a    [num_vec];
  logic [w-1:0] vec_b    [num_vec];
  logic         vec_sub  [num_vec];
  logic [w-1:0] vec_z    [num_vec];
  logic [3:0]   vec_flags[num_vec];
  int           vec_cnt;

  // accepted items in order together with their accept cycle
  int     pend_item[$];
  int     pend_cyc[$];
  int     cycle_cnt;
  int     cur_item;
  int     issued;
  int     done_cnt;
  integer seed;

  fpu_add_sub #(.e_p(e_w), .m_p(m_w)) dut_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .en_i            (en_i),
    .v_i             (v_i),
    .a_i             (a_i),
    .b_i             (b_i),
    .sub_i           (sub_i),
    .ready_o         (ready_o),
    .v_o             (v_o),
    .z_o             (z_o),
    .unimplemented_o (unimplemented_o),
    .invalid_o       (invalid_o),
    .overflow_o      (overflow_o),
    .underflow_o     (underflow_o),
    .yumi_i          (yumi_i)
  );

  bind fpu_add_sub fpu_add_sub_sva #(.e_p(e_p), .m_p(m_p)) sva_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .v_o             (v_o),
    .yumi_i          (yumi_i),
    .z_o             (z_o),
    .unimplemented_o (unimplemented_o),
    .overflow_o      (overflow_o),
    .underflow_o     (underflow_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic add_entry(input string name, input logic [w-1:0] a, input logic [w-1:0] b,
                           input logic sub, input logic [w-1:0] z, input logic [3:0] flags);
    vec_name[vec_cnt]  = name;
    vec_a[vec_cnt]     = a;
    vec_b[vec_cnt]     = b;
    vec_sub[vec_cnt]   = sub;
    vec_z[vec_cnt]     = z;
    vec_flags[vec_cnt] = flags;
    vec_cnt++;
  endtask

  // expected values worked out by hand for single precision
  task automatic fill_table();
    vec_cnt = 0;
    add_entry("add_basic", 32'h3fc00000, 32'h40100000, 1'b0, 32'h40700000, fl_none);
    add_entry("sub_basic", 32'h40400000, 32'h3f800000, 1'b1, 32'h40000000, fl_none);
    add_entry("mixed_sign", 32'hbfc00000, 32'h40100000, 1'b0, 32'h3f400000, fl_none);
    add_entry("neg_result", 32'h3f800000, 32'h40800000, 1'b1, 32'hc0400000, fl_none);
    add_entry("both_neg", 32'hc0000000, 32'hbf800000, 1'b0, 32'hc0400000, fl_none);
    add_entry("half_sum", 32'h3f000000, 32'h3f000000, 1'b0, 32'h3f800000, fl_none);
    add_entry("sub_wide", 32'h42c80000, 32'h3e800000, 1'b1, 32'h42c78000, fl_none);
    // ties go to the even neighbour
    add_entry("tie_even_down", 32'h3f800000, 32'h33800000, 1'b0, 32'h3f800000, fl_none);
    add_entry("tie_even_up", 32'h3f800001, 32'h33800000, 1'b0, 32'h3f800002, fl_none);
    add_entry("above_half", 32'h3f800000, 32'h33c00000, 1'b0, 32'h3f800001, fl_none);
    add_entry("sticky_add", 32'h3f800000, 32'h33800001, 1'b0, 32'h3f800001, fl_none);
    add_entry("sticky_sub", 32'h3f800000, 32'h30800000, 1'b1, 32'h3f800000, fl_none);
    add_entry("cancel_near", 32'h3f800001, 32'h3f800000, 1'b1, 32'h34000000, fl_none);
    add_entry("snan", 32'h7f800001, 32'h3f800000, 1'b0, `FPU_QNAN(e_w, m_w), fl_inv);
    add_entry("qnan", 32'hffc00123, 32'h3f800000, 1'b0, `FPU_QNAN(e_w, m_w), fl_none);
    add_entry("inf_minus_inf", 32'h7f800000, 32'h7f800000, 1'b1, `FPU_QNAN(e_w, m_w), fl_inv);
    add_entry("inf_plus_num", 32'h7f800000, 32'h3f800000, 1'b0, `FPU_INF(1'b0, e_w, m_w),
              fl_none);
    add_entry("num_minus_inf", 32'h3f800000, 32'h7f800000, 1'b1, `FPU_INF(1'b1, e_w, m_w),
              fl_none);
    add_entry("denormal", 32'h00000001, 32'h3f800000, 1'b0, `FPU_QNAN(e_w, m_w), fl_unimp);
    add_entry("overflow", 32'h7f7fffff, 32'h7f7fffff, 1'b0, `FPU_INF(1'b0, e_w, m_w), fl_ovf);
    add_entry("underflow", 32'h00800001, 32'h00800000, 1'b1, `FPU_ZERO(1'b0, e_w, m_w),
              fl_unf);
    add_entry("underflow_neg", 32'h00800000, 32'h00800001, 1'b1, `FPU_ZERO(1'b1, e_w, m_w),
              fl_unf);
    add_entry("x_minus_x", 32'h40400000, 32'h40400000, 1'b1, `FPU_ZERO(1'b0, e_w, m_w),
              fl_none);
    add_entry("neg_plus_pos", 32'hc0400000, 32'h40400000, 1'b0, `FPU_ZERO(1'b0, e_w, m_w),
              fl_none);
  endtask

  task automatic check_result();
    int         item;
    int         idx;
    int         lat;
    logic [3:0] got_flags;
    assert (pend_item.size() > 0) else begin
      stop_with_failure("a result came out with no operation outstanding");
    end
    item      = pend_item.pop_front();
    idx       = item % num_vec;
    lat       = cycle_cnt - pend_cyc.pop_front();
    got_flags = {invalid_o, unimplemented_o, overflow_o, underflow_o};
    assert (z_o === vec_z[idx]) else begin
      stop_with_failure($sformatf("Mismatch %s z: expected %h actual %h",
                                  vec_name[idx], vec_z[idx], z_o));
    end
    assert (got_flags === vec_flags[idx]) else begin
      stop_with_failure($sformatf("Mismatch %s flags: expected %b actual %b",
                                  vec_name[idx], vec_flags[idx], got_flags));
    end
    // first pass runs without gaps so latency is fixed
    if (item < num_vec) begin
      assert (lat == 3) else begin
        stop_with_failure($sformatf("Mismatch %s latency: expected 3 actual %0d",
                                    vec_name[idx], lat));
      end
    end
    done_cnt++;
  endtask

  // handshakes are sampled on the rising edge
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (v_o && yumi_i) begin
        check_result();
      end
      if (v_i && ready_o) begin
        pend_item.push_back(cur_item);
        pend_cyc.push_back(cycle_cnt);
        issued++;
      end
    end
    cycle_cnt++;
  end

  task automatic run_pass(input int last, input bit gaps);
    int idx;
    while (done_cnt < last) begin
      @(negedge clk_i);
      if (issued < last && (!gaps || ($random(seed) & 32'd3) != 0)) begin
        idx      = issued % num_vec;
        v_i      = 1'b1;
        a_i      = vec_a[idx];
        b_i      = vec_b[idx];
        sub_i    = vec_sub[idx];
        cur_item = issued;
      end else begin
        v_i = 1'b0;
      end
      yumi_i = v_o && (!gaps || ($random(seed) & 32'd1) != 0);
    end
    v_i    = 1'b0;
    yumi_i = 1'b0;
  endtask

  initial begin
    seed      = 32'h4ab3;
    reset_i   = 1'b1;
    en_i      = 1'b1;
    v_i       = 1'b0;
    a_i       = '0;
    b_i       = '0;
    sub_i     = 1'b0;
    yumi_i    = 1'b0;
    cur_item  = 0;
    issued    = 0;
    done_cnt  = 0;
    cycle_cnt = 0;
    fill_table();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // back to back first and then random gaps with back-pressure
    run_pass(num_vec, 1'b0);
    run_pass(num_items, 1'b1);
    // pipeline is drained so nothing more may come out
    repeat (3) @(negedge clk_i);
    if (!v_o) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("a result came out after every operation had completed");
    end
  end

  initial begin
    repeat (40 * num_items + 20) @(posedge clk_i);
    stop_with_failure("results stopped arriving before the watchdog limit");
  end

endmodule

// ==== fpu_add_sub.f ====
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_class_if.sv
hw/fpu_preprocess.sv
hw/fpu_align.sv
hw/fpu_normalize.sv
hw/fpu_round_pack.sv
hw/fpu_add_sub.sv
tests/fpu_add_sub_sva.sv
tests/fpu_add_sub_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it
# the exit status is the one of the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module fpu_add_sub_tb -Mdir obj_dir -f fpu_add_sub.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vfpu_add_sub_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

echo "simulation finished"
exit 0
